//--- rtl/pcs_pkg.sv
// *************************************************
// pcs_pkg
// shared widths, sync header codes, block lock
// thresholds and state encodings for the 64b/66b
// loopback PCS
// *************************************************
package pcs_pkg;

	localparam int HEAD_W  = 2;                // sync header bits
	localparam int DATA_W  = 64;               // payload bits per block
	localparam int BLOCK_W = HEAD_W + DATA_W;  // full 66-bit block

	// sync header, bit 0 is first on the line
	typedef enum logic [HEAD_W-1:0] {
		SYNC_DATA = 2'b01,  // all-data block
		SYNC_CTRL = 2'b10   // block with control characters
	} sync_hdr_t;           // 00 and 11 never appear on a clean link

	// block lock thresholds
	localparam int LOCK_GOOD_N = 64;  // consecutive good headers to lock
	localparam int LOCK_WIN_N  = 64;  // header window while locked
	localparam int LOCK_BAD_N  = 16;  // bad headers per window that drop lock

	// x^58 + x^39 + 1 scrambler
	localparam int          SCR_W    = 58;        // state length
	localparam logic [57:0] SCR_SEED = '1;        // state after reset

	// transceiver reset sequencer
	typedef enum logic [1:0] {
		RST_ANALOG    = 2'd0,  // analog reset held
		RST_WAIT_CAL  = 2'd1,  // analog released, calibration running
		RST_WAIT_LOCK = 2'd2,  // rx only, waiting for cdr lock to data
		RST_READY     = 2'd3   // digital reset released
	} rst_state_t;

	// block lock
	typedef enum logic [1:0] {
		LOCK_HUNT      = 2'd0,  // counting consecutive good headers
		LOCK_SLIP_WAIT = 2'd1,  // slip in flight through the gearbox
		LOCK_LOCKED    = 2'd2   // aligned, counting bad headers per window
	} lock_state_t;

endpackage

//--- rtl/pcs_block_if.sv
// *************************************************
// pcs_block_if
// 66-bit block stream between PCS stages, one block
// per clock while valid is high, no back-pressure
// *************************************************
interface pcs_block_if;
	import pcs_pkg::*;

	sync_hdr_t         header;  // sync header as received
	logic [DATA_W-1:0] data;    // payload, bit 0 first
	logic              valid;   // block present this cycle
	logic              lock;    // source is block aligned

	modport source (
		output header,
		output data,
		output valid,
		output lock
	);

	modport sink (
		input header,
		input data,
		input valid,
		input lock
	);

endinterface

//--- rtl/xcvr_reset_seq.sv
// *************************************************
// xcvr_reset_seq
// drives analog and digital resets of a hard
// transceiver from cal_busy and lock to data, and
// flags each PCS path ready once it is out of reset
// *************************************************
module xcvr_reset_seq #(
	parameter int RESET_HOLD_CYCLES = 16  // analog reset hold, in OSC_50m cycles
) (
	input  logic OSC_50m,
	input  logic FAKE_RESET,

	input  logic tx_cal_busy_i,         // tx calibration running
	input  logic rx_cal_busy_i,         // rx calibration running
	input  logic rx_is_lockedtodata_i,  // rx cdr locked to incoming data

	output logic tx_analogreset_o,
	output logic tx_digitalreset_o,
	output logic rx_analogreset_o,
	output logic rx_digitalreset_o,
	output logic tx_ready_o,            // tx PCS may run
	output logic rx_ready_o             // rx PCS may run
);
	import pcs_pkg::*;

	localparam int HOLD_CW = $clog2(RESET_HOLD_CYCLES + 1);

	rst_state_t         tx_state_q;
	rst_state_t         rx_state_q;
	logic [HOLD_CW-1:0] hold_cnt_q;   // shared analog hold timer
	logic               hold_done;
	logic               tx_ready_q;
	logic               rx_ready_q;

	assign hold_done = (hold_cnt_q == HOLD_CW'(RESET_HOLD_CYCLES - 1));

	// both paths sit in RST_ANALOG together, so one timer serves both
	always_ff @(posedge OSC_50m) begin
		if (FAKE_RESET) begin
			hold_cnt_q <= '0;
		end else if (tx_state_q == RST_ANALOG && !hold_done) begin
			hold_cnt_q <= hold_cnt_q + 1'b1;
		end
	end

	// tx path, no data lock to wait for
	always_ff @(posedge OSC_50m) begin
		if (FAKE_RESET) begin
			tx_state_q <= RST_ANALOG;
			tx_ready_q <= 1'b0;
		end else begin
			tx_ready_q <= (tx_state_q == RST_READY);  // one cycle after digital release
			case (tx_state_q)
				RST_ANALOG:   if (hold_done) tx_state_q <= RST_WAIT_CAL;
				RST_WAIT_CAL: if (!tx_cal_busy_i) tx_state_q <= RST_READY;
				RST_READY:    tx_state_q <= RST_READY;
				default:      tx_state_q <= RST_ANALOG;  // RST_WAIT_LOCK unused on tx
			endcase
		end
	end

	// rx path, needs cal done and cdr locked to data
	always_ff @(posedge OSC_50m) begin
		if (FAKE_RESET) begin
			rx_state_q <= RST_ANALOG;
			rx_ready_q <= 1'b0;
		end else begin
			// falls together with the digital reset rising on lock loss
			rx_ready_q <= (rx_state_q == RST_READY) && rx_is_lockedtodata_i;
			case (rx_state_q)
				RST_ANALOG: begin
					if (hold_done) rx_state_q <= RST_WAIT_CAL;
				end
				RST_WAIT_CAL: begin
					if (!rx_cal_busy_i && rx_is_lockedtodata_i)
						rx_state_q <= RST_READY;
					else if (!rx_cal_busy_i)
						rx_state_q <= RST_WAIT_LOCK;  // cal done, cdr still hunting
				end
				RST_WAIT_LOCK: begin
					if (!rx_cal_busy_i && rx_is_lockedtodata_i) rx_state_q <= RST_READY;
				end
				RST_READY: begin
					if (!rx_is_lockedtodata_i) rx_state_q <= RST_WAIT_LOCK;  // lost data
				end
				default: rx_state_q <= RST_ANALOG;
			endcase
		end
	end

	assign tx_analogreset_o  = (tx_state_q == RST_ANALOG);
	assign rx_analogreset_o  = (rx_state_q == RST_ANALOG);
	assign tx_digitalreset_o = (tx_state_q != RST_READY);  // held until cal done
	assign rx_digitalreset_o = (rx_state_q != RST_READY);  // held until cal and lock
	assign tx_ready_o        = tx_ready_q;
	assign rx_ready_o        = rx_ready_q;

endmodule

//--- rtl/pcs_scrambler.sv
// *************************************************
// pcs_scrambler
// self-synchronous x^58+x^39+1 scrambler over the
// 64-bit payload, or descrambler when DESCRAMBLE=1
// *************************************************
module pcs_scrambler #(
	parameter bit DESCRAMBLE = 1'b0  // 0 scramble for tx, 1 descramble for rx
) (
	input  logic                      OSC_50m,
	input  logic                      FAKE_RESET,
	input  logic                      en_i,               // path ready, low holds seed
	input  pcs_pkg::sync_hdr_t        blk_in_header_i,
	input  logic [pcs_pkg::DATA_W-1:0] blk_in_data_i,
	input  logic                      blk_in_valid_i,
	output pcs_pkg::sync_hdr_t        blk_out_header_o,
	output logic [pcs_pkg::DATA_W-1:0] blk_out_data_o,
	output logic                      blk_out_valid_o
);
	import pcs_pkg::*;

	logic [SCR_W-1:0]  state_q;     // bit 0 holds the newest line bit
	logic [SCR_W-1:0]  state_next;
	logic [DATA_W-1:0] data_next;

	// one payload bit per step, lsb first
	always_comb begin
		state_next = state_q;
		for (int i = 0; i < DATA_W; i++) begin
			data_next[i] = blk_in_data_i[i] ^ state_next[38] ^ state_next[57];  // taps 39, 58
			if (DESCRAMBLE)
				state_next = {state_next[SCR_W-2:0], blk_in_data_i[i]};  // received bit
			else
				state_next = {state_next[SCR_W-2:0], data_next[i]};      // sent bit
		end
	end

	always_ff @(posedge OSC_50m) begin
		if (FAKE_RESET || !en_i) begin
			state_q          <= SCR_SEED;
			blk_out_header_o <= SYNC_CTRL;  // idle control block with zero payload
			blk_out_data_o   <= '0;
			blk_out_valid_o  <= 1'b0;
		end else begin
			if (blk_in_valid_i) state_q <= state_next;  // advance only on real blocks
			blk_out_header_o <= blk_in_header_i;        // header is never scrambled
			blk_out_data_o   <= data_next;
			blk_out_valid_o  <= blk_in_valid_i;
		end
	end

endmodule

//--- rtl/pcs_rx_gearbox.sv
// *************************************************
// pcs_rx_gearbox
// picks a 66-bit window out of the last two serdes
// words, bit offset moved by one per slip request
// *************************************************
module pcs_rx_gearbox (
	input  logic                        OSC_50m,
	input  logic                        FAKE_RESET,
	input  logic                        en_i,    // rx path ready
	input  logic [pcs_pkg::BLOCK_W-1:0] raw_i,   // word from the serdes, bit 0 oldest
	input  logic                        slip_i,  // move window by one bit
	pcs_block_if.source                 blk_o
);
	import pcs_pkg::*;

	logic [BLOCK_W-1:0]   prev_q;    // word n-1
	logic [2*BLOCK_W-1:0] cat;       // word n above word n-1
	logic [BLOCK_W-1:0]   win;
	logic [6:0]           offset_q;  // 0 to 65
	logic                 valid_q;

	assign cat = {raw_i, prev_q};
	assign win = cat[offset_q +: BLOCK_W];

	// offset update lands after this cycle's window is taken
	always_ff @(posedge OSC_50m) begin
		if (FAKE_RESET || !en_i) begin
			offset_q <= '0;
			valid_q  <= 1'b0;
		end else begin
			valid_q <= 1'b1;  // one window every clock
			if (slip_i) begin
				if (offset_q == 7'(BLOCK_W - 1))
					offset_q <= '0;  // wrap
				else
					offset_q <= offset_q + 1'b1;
			end
		end
	end

	always_ff @(posedge OSC_50m) begin
		prev_q       <= raw_i;
		blk_o.header <= sync_hdr_t'(win[HEAD_W-1:0]);  // may hold 00 or 11 while hunting
		blk_o.data   <= win[BLOCK_W-1:HEAD_W];
	end

	assign blk_o.valid = valid_q;
	assign blk_o.lock  = 1'b0;  // alignment is not known here

endmodule

//--- rtl/pcs_block_lock.sv
// *************************************************
// pcs_block_lock
// sync header block lock, slips the gearbox until
// headers line up and drops lock on too many errors
// *************************************************
module pcs_block_lock (
	input  logic        OSC_50m,
	input  logic        FAKE_RESET,
	input  logic        en_i,    // rx path ready
	pcs_block_if.sink   blk_i,   // from gearbox
	pcs_block_if.source blk_o,   // to descrambler
	output logic        slip_o   // one-cycle pulse to the gearbox
);
	import pcs_pkg::*;

	localparam int SLIP_WAIT_N = 2;  // blocks still at the old offset after a slip
	localparam int GOOD_CW     = $clog2(LOCK_GOOD_N);
	localparam int WIN_CW      = $clog2(LOCK_WIN_N);
	localparam int BAD_CW      = $clog2(LOCK_BAD_N);
	localparam int WAIT_CW     = $clog2(SLIP_WAIT_N);

	lock_state_t        state_q;
	logic [GOOD_CW-1:0] good_cnt_q;  // consecutive good headers
	logic [WIN_CW-1:0]  win_cnt_q;   // position in the error window
	logic [BAD_CW-1:0]  bad_cnt_q;   // bad headers in this window
	logic [WAIT_CW-1:0] wait_cnt_q;
	logic               hdr_ok;
	logic               valid_q;
	logic               lock_q;

	assign hdr_ok = (blk_i.header == SYNC_DATA) || (blk_i.header == SYNC_CTRL);

	always_ff @(posedge OSC_50m) begin
		if (FAKE_RESET || !en_i) begin
			state_q    <= LOCK_HUNT;
			good_cnt_q <= '0;
			win_cnt_q  <= '0;
			bad_cnt_q  <= '0;
			wait_cnt_q <= '0;
			slip_o     <= 1'b0;
		end else begin
			slip_o <= 1'b0;
			if (blk_i.valid) begin
				case (state_q)
					LOCK_HUNT: begin
						if (!hdr_ok) begin
							slip_o     <= 1'b1;  // wrong offset, try the next bit
							wait_cnt_q <= '0;
							good_cnt_q <= '0;
							state_q    <= LOCK_SLIP_WAIT;
						end else if (good_cnt_q == GOOD_CW'(LOCK_GOOD_N - 1)) begin
							win_cnt_q <= '0;
							bad_cnt_q <= '0;
							state_q   <= LOCK_LOCKED;
						end else begin
							good_cnt_q <= good_cnt_q + 1'b1;
						end
					end
					LOCK_SLIP_WAIT: begin
						// skip blocks taken before the new offset applies
						if (wait_cnt_q == WAIT_CW'(SLIP_WAIT_N - 1)) begin
							good_cnt_q <= '0;
							state_q    <= LOCK_HUNT;
						end else begin
							wait_cnt_q <= wait_cnt_q + 1'b1;
						end
					end
					LOCK_LOCKED: begin
						if (!hdr_ok && bad_cnt_q == BAD_CW'(LOCK_BAD_N - 1)) begin
							slip_o     <= 1'b1;  // too many errors, start over
							wait_cnt_q <= '0;
							good_cnt_q <= '0;
							state_q    <= LOCK_SLIP_WAIT;
						end else if (win_cnt_q == WIN_CW'(LOCK_WIN_N - 1)) begin
							win_cnt_q <= '0;  // window ends, errors forgotten
							bad_cnt_q <= '0;
						end else begin
							win_cnt_q <= win_cnt_q + 1'b1;
							if (!hdr_ok) bad_cnt_q <= bad_cnt_q + 1'b1;
						end
					end
					default: state_q <= LOCK_HUNT;
				endcase
			end
		end
	end

	// flags follow the state seen by the block they go with
	always_ff @(posedge OSC_50m) begin
		if (FAKE_RESET || !en_i) begin
			valid_q <= 1'b0;
			lock_q  <= 1'b0;
		end else begin
			valid_q <= blk_i.valid && (state_q == LOCK_LOCKED);
			lock_q  <= (state_q == LOCK_LOCKED);
		end
	end

	always_ff @(posedge OSC_50m) begin
		blk_o.header <= blk_i.header;  // one cycle pass-through
		blk_o.data   <= blk_i.data;
	end

	assign blk_o.valid = valid_q;
	assign blk_o.lock  = lock_q;

endmodule

//--- rtl/pcs_loopback_top.sv
// *************************************************
// pcs_loopback_top
// single-lane 64b/66b PCS, tx scrambler, rx gearbox,
// block lock and descrambler under a transceiver
// reset sequencer
// *************************************************
module pcs_loopback_top #(
	parameter int RESET_HOLD_CYCLES = 16  // analog reset hold
) (
	input  logic                        OSC_50m,
	input  logic                        FAKE_RESET,

	// tx block stream
	input  pcs_pkg::sync_hdr_t          tx_header_i,
	input  logic [pcs_pkg::DATA_W-1:0]  tx_data_i,
	input  logic                        tx_valid_i,
	output logic [pcs_pkg::BLOCK_W-1:0] tx_block_o,   // to serdes, header in low bits

	// rx block stream
	input  logic [pcs_pkg::BLOCK_W-1:0] rx_raw_i,     // from serdes, unaligned
	output pcs_pkg::sync_hdr_t          rx_header_o,
	output logic [pcs_pkg::DATA_W-1:0]  rx_data_o,
	output logic                        rx_valid_o,
	output logic                        rx_block_lock_o,

	// hard transceiver status and resets
	input  logic                        tx_cal_busy_i,
	input  logic                        rx_cal_busy_i,
	input  logic                        rx_is_lockedtodata_i,
	output logic                        tx_analogreset_o,
	output logic                        tx_digitalreset_o,
	output logic                        rx_analogreset_o,
	output logic                        rx_digitalreset_o,
	output logic                        tx_ready_o,
	output logic                        rx_ready_o
);
	import pcs_pkg::*;

	sync_hdr_t         tx_scr_header;  // scrambled tx block
	logic [DATA_W-1:0] tx_scr_data;
	logic              rx_slip;        // block lock to gearbox

	pcs_block_if gb_blk ();  // gearbox to block lock
	pcs_block_if lk_blk ();  // block lock to descrambler

	xcvr_reset_seq #(
		.RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
	) m_reset_seq (
		.OSC_50m             (OSC_50m),
		.FAKE_RESET          (FAKE_RESET),
		.tx_cal_busy_i       (tx_cal_busy_i),
		.rx_cal_busy_i       (rx_cal_busy_i),
		.rx_is_lockedtodata_i(rx_is_lockedtodata_i),
		.tx_analogreset_o    (tx_analogreset_o),
		.tx_digitalreset_o   (tx_digitalreset_o),
		.rx_analogreset_o    (rx_analogreset_o),
		.rx_digitalreset_o   (rx_digitalreset_o),
		.tx_ready_o          (tx_ready_o),
		.rx_ready_o          (rx_ready_o)
	);

	pcs_scrambler #(
		.DESCRAMBLE(1'b0)
	) m_tx_scrambler (
		.OSC_50m         (OSC_50m),
		.FAKE_RESET      (FAKE_RESET),
		.en_i            (tx_ready_o),
		.blk_in_header_i (tx_header_i),
		.blk_in_data_i   (tx_data_i),
		.blk_in_valid_i  (tx_valid_i),
		.blk_out_header_o(tx_scr_header),
		.blk_out_data_o  (tx_scr_data),
		.blk_out_valid_o ()  // no serdes strobe, a block goes out every clock
	);

	assign tx_block_o = {tx_scr_data, tx_scr_header};  // header goes out first

	pcs_rx_gearbox m_rx_gearbox (
		.OSC_50m   (OSC_50m),
		.FAKE_RESET(FAKE_RESET),
		.en_i      (rx_ready_o),
		.raw_i     (rx_raw_i),
		.slip_i    (rx_slip),
		.blk_o     (gb_blk.source)
	);

	pcs_block_lock m_rx_block_lock (
		.OSC_50m   (OSC_50m),
		.FAKE_RESET(FAKE_RESET),
		.en_i      (rx_ready_o),
		.blk_i     (gb_blk.sink),
		.blk_o     (lk_blk.source),
		.slip_o    (rx_slip)
	);

	pcs_scrambler #(
		.DESCRAMBLE(1'b1)
	) m_rx_descrambler (
		.OSC_50m         (OSC_50m),
		.FAKE_RESET      (FAKE_RESET),
		.en_i            (rx_ready_o),
		.blk_in_header_i (lk_blk.header),
		.blk_in_data_i   (lk_blk.data),
		.blk_in_valid_i  (lk_blk.valid),  // only aligned blocks advance the state
		.blk_out_header_o(rx_header_o),
		.blk_out_data_o  (rx_data_o),
		.blk_out_valid_o (rx_valid_o)
	);

	assign rx_block_lock_o = lk_blk.lock;

endmodule

//--- testbench/tb_pcs_model.svh
// *************************************************
// tb_pcs_model
// random source, reference scrambler, sent block
// queue and compare tasks for the loopback testbench
// *************************************************
`ifndef TB_PCS_MODEL_SVH
`define TB_PCS_MODEL_SVH

typedef struct packed {
	sync_hdr_t         hdr;
	logic [DATA_W-1:0] data;
} sent_blk_t;

logic [15:0]      lfsr_q = 16'd59443;  // galois lfsr state
logic [SCR_W-1:0] scr_q  = SCR_SEED;   // model scrambler state, bit 0 newest
sent_blk_t        sent_q[$];           // blocks driven into tx, newest last
int               checks;
int               errors;
int               timeouts;

// one lfsr step per bit taken
function automatic logic [63:0] rand_bits(input int n);
	logic [63:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r[i] = lfsr_q[0];
		lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
	end
	return r;
endfunction

// x^58+x^39+1 over a line history, oldest bit first
function automatic logic [DATA_W-1:0] scramble_model(input logic [DATA_W-1:0] din,
		input bit advance);
	logic              line [0:SCR_W+DATA_W-1];
	logic [DATA_W-1:0] dout;
	for (int m = 0; m < SCR_W; m++) line[SCR_W-1-m] = scr_q[m];
	for (int i = 0; i < DATA_W; i++) begin
		dout[i] = din[i] ^ line[SCR_W+i-39] ^ line[SCR_W+i-58];  // 39 and 58 bits back
		line[SCR_W+i] = dout[i];
	end
	if (advance) begin
		for (int m = 0; m < SCR_W; m++) scr_q[m] = line[SCR_W+DATA_W-1-m];
	end
	return dout;
endfunction

task automatic check_block(input sync_hdr_t got_h, input logic [DATA_W-1:0] got_d,
		input sync_hdr_t exp_h, input logic [DATA_W-1:0] exp_d, input string what);
	checks++;
	if (got_h !== exp_h || got_d !== exp_d) begin
		errors++;
		$display("** Error at %0d ns: %s is %b %h, expected %b %h", $time, what,
			got_h, got_d, exp_h, exp_d);
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic report_timeout(input string what);
	timeouts++;
	$display("timeout at %0d ns: %s never happened", $time, what);
endtask

`endif

//--- testbench/tb_pcs_loopback.sv
// *************************************************
// tb_pcs_loopback
// drives the loopback PCS with random blocks through
// a serdes model with bit offset, checks reset
// sequencing, scrambling, block lock and data
// *************************************************
module tb_pcs_loopback;
	timeunit 1ns;
	timeprecision 1ps;
	import pcs_pkg::*;

	`include "tb_pcs_model.svh"

	logic OSC_50m = 1'b0;
	logic FAKE_RESET, tx_valid_i, rx_valid_o, rx_block_lock_o;
	logic tx_cal_busy_i, rx_cal_busy_i, rx_is_lockedtodata_i;
	logic tx_analogreset_o, tx_digitalreset_o, rx_analogreset_o, rx_digitalreset_o;
	logic tx_ready_o, rx_ready_o;
	sync_hdr_t tx_header_i, rx_header_o, hdr_w, exp_h;
	logic [DATA_W-1:0] tx_data_i, rx_data_o, data_w, exp_d;
	logic [BLOCK_W-1:0] tx_block_o, rx_raw_i, line_w, serdes_q;
	logic [2*BLOCK_W-1:0] pair_w;
	int bit_off, lag, tx_cal_n, rx_cal_n, lock_n, cyc, n, idx;
	bit corrupt_hdr, cdr_drop, tx_check_on, have_exp, rx_check_on, rx_first, startup_mon;

	pcs_loopback_top #(.RESET_HOLD_CYCLES(16)) i_dut (.*);

	always #10 OSC_50m = ~OSC_50m;

	// transceiver status, cal then cdr lock, cycles counted from reset release
	always @(posedge OSC_50m) begin
		if (FAKE_RESET) begin
			cyc <= 0;
		end else begin
			cyc                  <= cyc + 1;
			tx_cal_busy_i        <= (cyc < tx_cal_n);
			rx_cal_busy_i        <= (cyc < rx_cal_n);
			rx_is_lockedtodata_i <= (cyc >= lock_n) && !cdr_drop;
		end
	end

	// serdes, one word of delay then the stream rotated by bit_off
	always @(posedge OSC_50m) begin
		line_w = corrupt_hdr ? {tx_block_o[BLOCK_W-1:HEAD_W], 2'b00} : tx_block_o;
		pair_w = {line_w, serdes_q};
		serdes_q <= line_w;
		rx_raw_i <= pair_w[bit_off +: BLOCK_W];
	end

	always @(posedge OSC_50m) begin
		if (!FAKE_RESET) begin
			hdr_w = rand_bits(1) ? SYNC_DATA : SYNC_CTRL;
			data_w = rand_bits(DATA_W);
			tx_header_i <= hdr_w;
			tx_data_i   <= data_w;
			tx_valid_i  <= 1'b1;
			sent_q.push_back({hdr_w, data_w});
			if (sent_q.size() > 12) sent_q.pop_front();  // only the last few matter
		end
	end

	// tx output against the model block computed one cycle before
	always @(negedge OSC_50m) begin
		if (tx_check_on) begin
			if (have_exp)
				check_block(sync_hdr_t'(tx_block_o[HEAD_W-1:0]), tx_block_o[BLOCK_W-1:HEAD_W],
					exp_h, exp_d, "tx block");
			if (!tx_ready_o) begin
				exp_h = SYNC_CTRL;  // idle while tx path in reset
				exp_d = '0;
				scr_q = SCR_SEED;
			end else begin
				exp_h = tx_header_i;
				exp_d = scramble_model(tx_data_i, tx_valid_i);
			end
			have_exp = 1'b1;
		end
	end

	// first valid block after lock carries a stale descrambler state
	always @(negedge OSC_50m) begin
		if (!rx_check_on || !rx_valid_o) begin
			rx_first = 1'b1;
		end else if (rx_first) begin
			rx_first = 1'b0;
		end else begin
			idx = sent_q.size() - 1 - lag;
			if (idx >= 0)
				check_block(rx_header_o, rx_data_o, sent_q[idx].hdr, sent_q[idx].data,
					"rx block");
		end
	end

	always @(negedge OSC_50m) begin
		if (startup_mon) begin
			if (tx_cal_busy_i) check_flag(tx_digitalreset_o, 1'b1, "tx digital reset in cal");
			if (rx_cal_busy_i || !rx_is_lockedtodata_i)
				check_flag(rx_digitalreset_o, 1'b1, "rx digital reset before cal and lock");
		end
	end

	initial begin
		FAKE_RESET = 1'b1;
		tx_header_i = SYNC_CTRL;
		tx_data_i = '0;
		tx_valid_i = 1'b0;
		rx_raw_i = '0;
		serdes_q = '0;
		tx_cal_busy_i = 1'b1;
		rx_cal_busy_i = 1'b1;
		rx_is_lockedtodata_i = 1'b0;
		tx_cal_n = 20 + int'(rand_bits(4));
		rx_cal_n = 40 + int'(rand_bits(4));
		lock_n = rx_cal_n + 5 + int'(rand_bits(3));
		bit_off = int'(rand_bits(7)) % BLOCK_W;
		lag = (bit_off == 0) ? 7 : 6;  // zero offset lands one word later in the gearbox
		rx_first = 1'b1;
		repeat (3) @(posedge OSC_50m);
		FAKE_RESET <= 1'b0;
		tx_check_on = 1'b1;
		startup_mon = 1'b1;
		@(negedge OSC_50m);
		check_flag(tx_analogreset_o & tx_digitalreset_o & rx_analogreset_o & rx_digitalreset_o,
			1'b1, "resets after reset");
		check_flag(tx_ready_o | rx_ready_o, 1'b0, "ready after reset");
		check_flag(rx_valid_o | rx_block_lock_o, 1'b0, "rx valid or lock after reset");
		n = 0;
		while (tx_analogreset_o && n < 40) begin
			@(negedge OSC_50m);
			n++;
		end
		check_flag(n == 16 && !rx_analogreset_o, 1'b1, "analog resets released after 16");
		for (n = 0; n < 200 && tx_digitalreset_o; n++) @(negedge OSC_50m);
		if (tx_digitalreset_o) report_timeout("tx digital reset release");
		check_flag(tx_ready_o, 1'b0, "tx ready with digital reset release");
		@(negedge OSC_50m);
		check_flag(tx_ready_o, 1'b1, "tx ready one cycle later");
		for (n = 0; n < 200 && rx_digitalreset_o; n++) @(negedge OSC_50m);
		if (rx_digitalreset_o) report_timeout("rx digital reset release");
		check_flag(rx_ready_o, 1'b0, "rx ready with digital reset release");
		@(negedge OSC_50m);
		check_flag(rx_ready_o, 1'b1, "rx ready one cycle later");
		for (n = 0; n < 66 * 70 && !rx_block_lock_o; n++) @(negedge OSC_50m);
		if (!rx_block_lock_o) report_timeout("block lock");
		@(posedge OSC_50m);
		rx_check_on = 1'b1;
		repeat (300) begin
			@(negedge OSC_50m);
			check_flag(rx_block_lock_o, 1'b1, "lock on clean headers");
		end
		@(posedge OSC_50m);
		rx_check_on = 1'b0;
		corrupt_hdr <= 1'b1;
		repeat (15) @(posedge OSC_50m);
		corrupt_hdr <= 1'b0;
		repeat (160) begin
			@(negedge OSC_50m);
			check_flag(rx_block_lock_o, 1'b1, "lock with 15 bad headers");
		end
		// a burst of twice 16 puts 16 bad headers in one window at any phase
		@(posedge OSC_50m);
		corrupt_hdr <= 1'b1;
		repeat (32) @(posedge OSC_50m);
		corrupt_hdr <= 1'b0;
		for (n = 0; n < 100 && rx_block_lock_o; n++) @(negedge OSC_50m);
		if (rx_block_lock_o) report_timeout("loss of lock on 16 bad headers");
		for (n = 0; n < 66 * 70 && !rx_block_lock_o; n++) @(negedge OSC_50m);
		if (!rx_block_lock_o) report_timeout("relock after loss");
		@(posedge OSC_50m);
		rx_check_on = 1'b1;
		repeat (200) @(negedge OSC_50m);
		@(posedge OSC_50m);
		rx_check_on = 1'b0;
		startup_mon = 1'b0;
		cdr_drop <= 1'b1;
		for (n = 0; n < 10 && !(rx_digitalreset_o && !rx_valid_o); n++) @(negedge OSC_50m);
		if (!(rx_digitalreset_o && !rx_valid_o)) report_timeout("rx reset on lost cdr lock");
		check_flag(rx_ready_o, 1'b0, "rx ready on lost cdr lock");
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- src.f
+incdir+testbench
rtl/pcs_pkg.sv
rtl/pcs_block_if.sv
rtl/xcvr_reset_seq.sv
rtl/pcs_scrambler.sv
rtl/pcs_rx_gearbox.sv
rtl/pcs_block_lock.sv
rtl/pcs_loopback_top.sv
testbench/tb_pcs_loopback.sv
